// ==== design/box_pkg.sv ====
package box_pkg;

  // number of colour channels carried in one beat.
  localparam int NUM_CH = 3;

  // window height and width in pixels.
  localparam int WIN = 5;

  localparam int PIX_W = 8;

  // five 8-bit pixels need 11 bits, the full window needs 13.
  localparam int COL_SUM_W = 11;
  localparam int SUM_W = 13;

  // cycles from a lane input valid to its output valid.
  localparam int LANE_LAT = 4;

  // one channel of one column. pix[0] is the top row.
  typedef struct packed {
    logic                            sol;
    logic [WIN-1:0][PIX_W-1:0]       pix;
  } lane_col_t;

  // upstream beat: one column for every channel and a start-of-line flag.
  typedef struct packed {
    logic                                  sol;
    logic [NUM_CH-1:0][WIN-1:0][PIX_W-1:0] pix;
  } col_in_t;

  // result of one channel for one column.
  typedef struct packed {
    logic [SUM_W-1:0] sum;
    logic [PIX_W-1:0] centre;
  } lane_res_t;

  // downstream beat.
  typedef struct packed {
    lane_res_t [NUM_CH-1:0] lane;
  } result_t;

endpackage

// ==== design/column_dispatch.sv ====
`timescale 1ns/1ps

module column_dispatch #(
  parameter int FIFO_DEPTH = 8
) (
  input  logic                                          clk,
  input  logic                                          rst_n,
  input  logic                                          i_col_valid,
  input  box_pkg::col_in_t                              i_col,
  input  logic                                          i_credit_return,
  output logic                                          o_lane_valid,
  output box_pkg::lane_col_t [box_pkg::NUM_CH-1:0]      o_lane_col
);
  import box_pkg::*;

  localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

  // credits currently held by upstream.
  logic [CNT_W-1:0] in_credits;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      o_lane_valid <= 1'b0;
    end else begin
      o_lane_valid <= i_col_valid;
    end
  end

  // every lane gets its own channel and a copy of the line start.
  always_ff @(posedge clk) begin
    if (i_col_valid) begin
      for (int ch = 0; ch < NUM_CH; ch++) begin
        o_lane_col[ch].sol <= i_col.sol;
        o_lane_col[ch].pix <= i_col.pix[ch];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      in_credits <= CNT_W'(FIFO_DEPTH);
    end else begin
      case ({i_col_valid, i_credit_return})
        2'b10:   in_credits <= in_credits - 1'b1;
        2'b01:   in_credits <= in_credits + 1'b1;
        default: in_credits <= in_credits;
      endcase
    end
  end

endmodule

// ==== design/window_sum_lane.sv ====
`timescale 1ns/1ps

module window_sum_lane (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                i_valid,
  input  box_pkg::lane_col_t  i_col,
  output logic                o_valid,
  output box_pkg::lane_res_t  o_res
);
  import box_pkg::*;

  // one valid bit per stage, shifted along with the data.
  logic [LANE_LAT-1:0] vld_sr;

  lane_col_t s1_col;

  logic [PIX_W:0]   s2_sum01;
  logic [PIX_W:0]   s2_sum23;
  logic [PIX_W-1:0] s2_p4;
  logic [PIX_W-1:0] s2_mid;
  logic             s2_sol;

  logic [COL_SUM_W-1:0] s3_col_sum;
  logic [PIX_W-1:0]     s3_mid;
  logic                 s3_sol;

  // column sums of k-1 .. k-4, newest in entry 0.
  logic [WIN-2:0][COL_SUM_W-1:0] col_hist;
  // sum of the four columns held in col_hist.
  logic [SUM_W-1:0]              part_sum;
  logic [1:0][PIX_W-1:0]         mid_hist;
  lane_res_t                     res_q;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      vld_sr <= '0;
    end else begin
      vld_sr <= {vld_sr[LANE_LAT-2:0], i_valid};
    end
  end

  always_ff @(posedge clk) begin
    if (i_valid) begin
      s1_col <= i_col;
    end
  end

  // adder tree, pair sums first.
  always_ff @(posedge clk) begin
    if (vld_sr[0]) begin
      s2_sum01 <= s1_col.pix[0] + s1_col.pix[1];
      s2_sum23 <= s1_col.pix[2] + s1_col.pix[3];
      s2_p4    <= s1_col.pix[4];
      s2_mid   <= s1_col.pix[WIN/2];
      s2_sol   <= s1_col.sol;
    end
  end

  always_ff @(posedge clk) begin
    if (vld_sr[1]) begin
      s3_col_sum <= COL_SUM_W'(s2_sum01) + COL_SUM_W'(s2_sum23) + COL_SUM_W'(s2_p4);
      s3_mid     <= s2_mid;
      s3_sol     <= s2_sol;
    end
  end

  // the output adds the current column to the four before it, while part_sum
  // drops the oldest column so it again covers exactly four.
  always_ff @(posedge clk) begin
    if (vld_sr[2]) begin
      col_hist <= {col_hist[WIN-3:0], s3_col_sum};
      mid_hist <= {mid_hist[0], s3_mid};
      if (s3_sol) begin
        col_hist[WIN-2:1] <= '0;
        mid_hist[1]       <= '0;
        part_sum          <= SUM_W'(s3_col_sum);
        res_q.sum         <= SUM_W'(s3_col_sum);
        res_q.centre      <= '0;
      end else begin
        part_sum     <= part_sum + SUM_W'(s3_col_sum) - SUM_W'(col_hist[WIN-2]);
        res_q.sum    <= part_sum + SUM_W'(s3_col_sum);
        res_q.centre <= mid_hist[1];
      end
    end
  end

  assign o_valid = vld_sr[LANE_LAT-1];
  assign o_res   = res_q;

endmodule

// ==== design/result_collector.sv ====
`timescale 1ns/1ps

module result_collector #(
  parameter int FIFO_DEPTH = 8
) (
  input  logic                                      clk,
  input  logic                                      rst_n,
  input  logic                                      i_lane_valid,
  input  box_pkg::lane_res_t [box_pkg::NUM_CH-1:0]  i_lane_res,
  input  logic                                      i_res_credit,
  output logic                                      o_res_valid,
  output box_pkg::result_t                          o_res,
  output logic                                      o_col_credit
);
  import box_pkg::*;

  localparam int PTR_W  = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
  localparam int CNT_W  = $clog2(FIFO_DEPTH + 1);
  // the sink may grant far more credits than the FIFO holds.
  localparam int CRED_W = 16;

  result_t          mem [FIFO_DEPTH];
  result_t          res_in;
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] fill;
  logic [CRED_W-1:0] out_credits;
  logic             send;

  assign res_in.lane = i_lane_res;

  // a result leaves only with data in hand and a credit from the sink.
  assign send = (fill != '0) && (out_credits != '0);

  always_ff @(posedge clk) begin
    if (i_lane_valid) begin
      mem[wr_ptr] <= res_in;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (i_lane_valid) begin
        wr_ptr <= (wr_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (send) begin
        rd_ptr <= (rd_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
    end
  end

  // no full check here. Input credits bound the number of columns in flight.
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      fill <= '0;
    end else begin
      case ({i_lane_valid, send})
        2'b10:   fill <= fill + 1'b1;
        2'b01:   fill <= fill - 1'b1;
        default: fill <= fill;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      out_credits <= '0;
    end else begin
      case ({i_res_credit, send})
        2'b10:   out_credits <= out_credits + 1'b1;
        2'b01:   out_credits <= out_credits - 1'b1;
        default: out_credits <= out_credits;
      endcase
    end
  end

  assign o_res_valid  = send;
  assign o_res        = mem[rd_ptr];
  // each popped entry frees one slot, which goes back upstream at once.
  assign o_col_credit = send;

endmodule

// ==== design/box_filter_top.sv ====
`timescale 1ns/1ps

module box_filter_top #(
  parameter int FIFO_DEPTH = 8
) (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               i_col_valid,
  input  box_pkg::col_in_t   i_col,
  output logic               o_col_credit,
  output logic               o_res_valid,
  output box_pkg::result_t   o_res,
  input  logic               i_res_credit
);
  import box_pkg::*;

  logic                      lane_in_valid;
  lane_col_t [NUM_CH-1:0]    lane_col;
  logic [NUM_CH-1:0]         lane_out_valid;
  lane_res_t [NUM_CH-1:0]    lane_res;

  column_dispatch #(
    .FIFO_DEPTH(FIFO_DEPTH)
  ) column_dispatch_inst (
    .clk             (clk),
    .rst_n           (rst_n),
    .i_col_valid     (i_col_valid),
    .i_col           (i_col),
    .i_credit_return (o_col_credit),
    .o_lane_valid    (lane_in_valid),
    .o_lane_col      (lane_col)
  );

  for (genvar ch = 0; ch < NUM_CH; ch++) begin : g_lane
    window_sum_lane window_sum_lane_inst (
      .clk     (clk),
      .rst_n   (rst_n),
      .i_valid (lane_in_valid),
      .i_col   (lane_col[ch]),
      .o_valid (lane_out_valid[ch]),
      .o_res   (lane_res[ch])
    );
  end

  // the lanes run in lockstep, so lane 0 speaks for all of them.
  result_collector #(
    .FIFO_DEPTH(FIFO_DEPTH)
  ) result_collector_inst (
    .clk          (clk),
    .rst_n        (rst_n),
    .i_lane_valid (lane_out_valid[0]),
    .i_lane_res   (lane_res),
    .i_res_credit (i_res_credit),
    .o_res_valid  (o_res_valid),
    .o_res        (o_res),
    .o_col_credit (o_col_credit)
  );

endmodule

// ==== dv/clk_rst_gen.sv ====
`timescale 1ns/1ps

module clk_rst_gen #(
  parameter int HALF_NS    = 5,
  parameter int RST_CYCLES = 3
) (
  output logic o_clk,
  output logic o_rst_n
);

  initial begin
    o_clk = 1'b0;
    forever #(HALF_NS) o_clk = ~o_clk;
  end

  // reset is released on the edge that ends the last reset cycle.
  initial begin
    o_rst_n = 1'b0;
    repeat (RST_CYCLES) @(posedge o_clk);
    o_rst_n <= 1'b1;
  end

endmodule

// ==== dv/box_filter_sva.sv ====
`timescale 1ns/1ps

module box_filter_sva #(
  parameter int CNT_W        = 4,
  parameter bit CHECK_RETURN = 1'b1
) (
  input logic             clk,
  input logic             rst_n,
  input logic             i_valid,
  input logic [CNT_W-1:0] i_credits,
  input logic             i_credit_pulse
);

  // a beat may only cross the interface while the sender holds a credit.
  valid_needs_credit: assert property (@(posedge clk) disable iff (!rst_n)
    i_valid |-> (i_credits != '0))
    else $error("beat sent while the credit count was zero");

  // the collector frees one input credit with every result it sends.
  credit_follows_send: assert property (@(posedge clk) disable iff (!rst_n)
    CHECK_RETURN |-> (i_credit_pulse == i_valid))
    else $error("credit return does not match the result handshake");

  quiet_in_reset: assert property (@(posedge clk)
    !rst_n |=> (rst_n || (!i_valid && !i_credit_pulse)))
    else $error("valid or credit pulse high during reset");

endmodule

bind result_collector box_filter_sva #(
  .CNT_W        (CRED_W),
  .CHECK_RETURN (1'b1)
) collector_sva_inst (
  .clk            (clk),
  .rst_n          (rst_n),
  .i_valid        (o_res_valid),
  .i_credits      (out_credits),
  .i_credit_pulse (o_col_credit)
);

bind column_dispatch box_filter_sva #(
  .CNT_W        (CNT_W),
  .CHECK_RETURN (1'b0)
) dispatch_sva_inst (
  .clk            (clk),
  .rst_n          (rst_n),
  .i_valid        (i_col_valid),
  .i_credits      (in_credits),
  .i_credit_pulse (i_credit_return)
);

// ==== dv/box_filter_tb.sv ====
`timescale 1ns/1ps

module box_filter_tb;
  import box_pkg::*;

  localparam int FIFO_DEPTH = 4;
  localparam int CLK_NS     = 10;
  localparam int NUM_STIM   = 8;

  localparam logic [1:0] PAT_RAND   = 2'd0;
  localparam logic [1:0] PAT_FULL   = 2'd1;
  localparam logic [1:0] PAT_RAMP   = 2'd2;
  localparam logic [1:0] PACE_EVERY = 2'd0;
  localparam logic [1:0] PACE_RAND  = 2'd1;
  localparam logic [1:0] PACE_BURST = 2'd2;

  typedef struct packed {
    logic [7:0] len;
    logic [1:0] pat;
    logic [1:0] pace;
  } stim_t;

  // expected sums are kept at full width so an overflow of the result shows up.
  typedef struct packed {
    logic [NUM_CH-1:0][31:0]      sum;
    logic [NUM_CH-1:0][PIX_W-1:0] centre;
  } exp_t;

  // the first entry starts with a credit pause, so results wait after reset.
  stim_t stim_tab [NUM_STIM] = '{
    '{8'd12, PAT_RAND, PACE_BURST}, '{8'd3, PAT_RAND, PACE_EVERY},
    '{8'd1, PAT_RAND, PACE_RAND},   '{8'd9, PAT_FULL, PACE_EVERY},
    '{8'd4, PAT_RAMP, PACE_RAND},   '{8'd20, PAT_RAND, PACE_RAND},
    '{8'd7, PAT_FULL, PACE_BURST},  '{8'd16, PAT_RAMP, PACE_EVERY}
  };

  logic       clk;
  logic       rst_n;
  logic       i_col_valid = 1'b0;
  col_in_t    i_col = '0;
  logic       i_res_credit = 1'b0;
  logic       o_col_credit;
  logic       o_res_valid;
  result_t    o_res;

  logic [1:0]  pace = PACE_BURST;
  int          pace_cnt = 0;
  int          granted = 0;
  int          spent = 0;
  int          returned = 0;
  int          credits_seen = 0;
  int          results_seen = 0;
  int unsigned col_sums [NUM_CH][256];
  logic [7:0]  mids [NUM_CH][256];
  exp_t        exp_q [$];
  exp_t        mon_exp;

  clk_rst_gen #(.HALF_NS(CLK_NS / 2), .RST_CYCLES(3)) clk_rst_gen_inst (
    .o_clk   (clk),
    .o_rst_n (rst_n)
  );

  box_filter_top #(.FIFO_DEPTH(FIFO_DEPTH)) box_filter_top_inst (
    .clk          (clk),
    .rst_n        (rst_n),
    .i_col_valid  (i_col_valid),
    .i_col        (i_col),
    .o_col_credit (o_col_credit),
    .o_res_valid  (o_res_valid),
    .o_res        (o_res),
    .i_res_credit (i_res_credit)
  );

  task automatic stop_with_failure();
    $display("SIMULATION FAILED");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      $display("CHECK FAILED %s actual=0x%0h expected=0x%0h", name, actual, expected);
      stop_with_failure();
    end
  endtask

  function automatic int total_cols();
    int n;
    n = 0;
    for (int i = 0; i < NUM_STIM; i++) begin
      n += int'(stim_tab[i].len);
    end
    return n;
  endfunction

  function automatic col_in_t make_column(input int line, input int k, input logic [1:0] pat);
    col_in_t col;
    col.sol = (k == 0);
    for (int ch = 0; ch < NUM_CH; ch++) begin
      for (int r = 0; r < WIN; r++) begin
        case (pat)
          PAT_FULL: col.pix[ch][r] = 8'hff;
          PAT_RAMP: col.pix[ch][r] = 8'(k * 7 + r * 3 + ch * 50 + line);
          default:  col.pix[ch][r] = 8'($urandom);
        endcase
      end
    end
    return col;
  endfunction

  // the window covers columns k-4 .. k of the current line, its centre is column k-2.
  task automatic model_column(input col_in_t col, input int k);
    exp_t        exp_res;
    int unsigned win;
    for (int ch = 0; ch < NUM_CH; ch++) begin
      col_sums[ch][k] = 0;
      for (int r = 0; r < WIN; r++) begin
        col_sums[ch][k] += 32'(col.pix[ch][r]);
      end
      mids[ch][k] = col.pix[ch][WIN / 2];
      win = 0;
      for (int j = (k >= WIN - 1) ? k - (WIN - 1) : 0; j <= k; j++) begin
        win += col_sums[ch][j];
      end
      exp_res.sum[ch]    = win;
      exp_res.centre[ch] = (k >= 2) ? mids[ch][k - 2] : 8'h00;
    end
    exp_q.push_back(exp_res);
  endtask

  task automatic drive_line(input int line, input stim_t st);
    col_in_t col;
    int      k;
    k = 0;
    while (k < int'(st.len)) begin
      @(posedge clk);
      if ((FIFO_DEPTH - spent + returned > 0) && ($urandom_range(0, 3) != 0)) begin
        col = make_column(line, k, st.pat);
        model_column(col, k);
        i_col_valid <= 1'b1;
        i_col       <= col;
        spent++;
        k++;
      end else begin
        i_col_valid <= 1'b0;
      end
    end
  endtask

  // downstream sink, which never holds more than three unused credits out.
  always @(posedge clk) begin
    if (!rst_n) begin
      i_res_credit <= 1'b0;
      pace_cnt     <= 0;
    end else begin
      pace_cnt <= pace_cnt + 1;
      if (granted - results_seen >= 3) begin
        i_res_credit <= 1'b0;
      end else if ((pace == PACE_EVERY) || ((pace == PACE_RAND) && ($urandom_range(0, 1) == 1))
                   || ((pace == PACE_BURST) && (pace_cnt % 24 >= 16))) begin
        i_res_credit <= 1'b1;
        granted++;
      end else begin
        i_res_credit <= 1'b0;
      end
    end
  end

  always @(negedge clk) begin
    if (rst_n) begin
      if (o_res_valid) begin
        check_value("o_res_valid credit held", 32'(credits_seen > results_seen), 32'd1);
        if (exp_q.size() == 0) begin
          $display("a result arrived with no column left to match it");
          stop_with_failure();
        end else begin
          mon_exp = exp_q.pop_front();
          for (int ch = 0; ch < NUM_CH; ch++) begin
            check_value($sformatf("o_res.lane[%0d].sum", ch),
                        32'(o_res.lane[ch].sum), mon_exp.sum[ch]);
            check_value($sformatf("o_res.lane[%0d].centre", ch),
                        32'(o_res.lane[ch].centre), 32'(mon_exp.centre[ch]));
          end
        end
        results_seen++;
      end
      if (o_col_credit) begin
        returned++;
      end
      if (i_res_credit) begin
        credits_seen++;
      end
    end
  end

  initial begin
    #(total_cols() * 40 * CLK_NS);
    $display("timeout: the results did not all arrive in the expected time");
    stop_with_failure();
  end

  initial begin
    void'($urandom(32'h3f1f03f4));
    wait (rst_n === 1'b1);
    for (int i = 0; i < NUM_STIM; i++) begin
      pace <= stim_tab[i].pace;
      drive_line(i, stim_tab[i]);
    end
    @(posedge clk);
    i_col_valid <= 1'b0;
    pace        <= PACE_EVERY;
    wait (results_seen == total_cols());
    repeat (20) @(posedge clk);
    check_value("o_col_credit pulses", 32'(returned), 32'(results_seen));
    check_value("upstream credits", 32'(FIFO_DEPTH - spent + returned), 32'(FIFO_DEPTH));
    $display("SIMULATION PASSED");
    $finish;
  end

endmodule

// ==== tb.f ====
design/box_pkg.sv
design/column_dispatch.sv
design/window_sum_lane.sv
design/result_collector.sv
design/box_filter_top.sv
dv/clk_rst_gen.sv
dv/box_filter_sva.sv
dv/box_filter_tb.sv

// ==== Makefile ====
VERILATOR  ?= verilator
TOP        := box_filter_tb
FILELIST   := tb.f
BUILD_DIR  := obj_dir
VFLAGS     := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only --timing --assert
LOG        := sim.log
PASS_MSG   := SIMULATION PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
